/* oq_macros.svh */
////////////////////////////////////////
// Widths and depths of the operand queue stage
// Included by the package and by every RTL file that sizes a queue
////////////////////////////////////////

`ifndef OQ_MACROS_SVH
`define OQ_MACROS_SVH

// Element and permutation word geometry
`define OQ_ELEN           64
`define OQ_NR_BANKS       4
`define OQ_VL_BITS        8

// Buffer depths
`define OQ_CMD_DEPTH      4
`define OQ_ALU_DEPTH      5
`define OQ_ST_DEPTH       2
`define OQ_PERM_DEPTH     4

// Queue count, the first three carry one element each
`define OQ_NR_QUEUES      5
`define OQ_NR_ELEN_QUEUES 3

`endif

/* oq_pkg.sv */
////////////////////////////////////////
// Payload, command and queue index types
////////////////////////////////////////

`include "oq_macros.svh"

package oq_pkg;

  // One vector element
  typedef logic [`OQ_ELEN-1:0] elen_t;

  // One element per register file bank
  typedef elen_t [`OQ_NR_BANKS-1:0] perm_word_t;

  // Element count of one command
  typedef logic [`OQ_VL_BITS-1:0] vl_t;

  typedef struct packed {
    vl_t vl;
  } oq_cmd_t;

  // Queue index, order matches the requester's port layout
  typedef enum logic [2:0] {
    alu_a,
    alu_b,
    st_a,
    perm_idx,
    perm_val
  } opqueue_e;

endpackage

/* operand_queue.sv */
`timescale 1ns/1ps
////////////////////////////////////////
// Operand queue with command buffer, data FIFO and read credit
// One module for element-wide and permutation-word payloads
////////////////////////////////////////

`include "oq_macros.svh"

module operand_queue #(
  parameter type         payload_t = oq_pkg::elen_t,
  parameter int unsigned DataDepth = `OQ_ALU_DEPTH,
  parameter int unsigned CmdDepth  = `OQ_CMD_DEPTH
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            flush_i,
  // Operand requester side
  input  oq_pkg::oq_cmd_t cmd_i,
  input  logic            cmd_valid_i,
  output logic            cmd_pop_o,
  input  payload_t        operand_i,
  input  logic            operand_valid_i,
  input  logic            operand_issued_i,
  output logic            operand_queue_ready_o,
  // Functional unit side
  output payload_t        operand_o,
  output logic            valid_o,
  input  logic            ready_i
);

  import oq_pkg::*;

  localparam int unsigned DataPtrW = (DataDepth > 1) ? $clog2(DataDepth) : 1;
  localparam int unsigned CmdPtrW  = (CmdDepth > 1) ? $clog2(CmdDepth) : 1;
  localparam int unsigned DataCntW = $clog2(DataDepth + 1);
  localparam int unsigned CmdCntW  = $clog2(CmdDepth + 1);

  payload_t            data_mem [DataDepth];
  logic [DataPtrW-1:0] data_wr_ptr_q;
  logic [DataPtrW-1:0] data_rd_ptr_q;
  logic [DataCntW-1:0] data_cnt_q;
  // Reads issued to the register file, data not back yet
  logic [DataCntW-1:0] inflight_q;

  oq_cmd_t             cmd_mem [CmdDepth];
  logic [CmdPtrW-1:0]  cmd_wr_ptr_q;
  logic [CmdPtrW-1:0]  cmd_rd_ptr_q;
  logic [CmdCntW-1:0]  cmd_cnt_q;
  oq_cmd_t             cmd_head;
  // Elements already handed out for the head command
  vl_t                 elem_cnt_q;
  logic                cmd_pop_q;

  logic data_pop;
  logic last_elem;
  logic cmd_done;
  logic cmd_full;

  assign cmd_head  = cmd_mem[cmd_rd_ptr_q];
  assign cmd_full  = (cmd_cnt_q == CmdCntW'(CmdDepth));
  assign valid_o   = (data_cnt_q != '0) && (cmd_cnt_q != '0);
  assign operand_o = data_mem[data_rd_ptr_q];
  assign data_pop  = valid_o && ready_i;
  assign last_elem = (elem_cnt_q == cmd_head.vl - 1'b1);
  assign cmd_done  = data_pop && last_elem;
  assign cmd_pop_o = cmd_pop_q;

  // Credit: reads in flight plus stored elements must fit the buffer
  assign operand_queue_ready_o =
    ({1'b0, inflight_q} + {1'b0, data_cnt_q}) < (DataCntW + 1)'(DataDepth);

  always_ff @(posedge clk_i) begin
    if (operand_valid_i) begin
      data_mem[data_wr_ptr_q] <= operand_i;
    end
    if (cmd_valid_i) begin
      cmd_mem[cmd_wr_ptr_q] <= cmd_i;
    end
  end

  ////////////////////////////////////////
  // Data side
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_wr_ptr_q <= '0;
      data_rd_ptr_q <= '0;
      data_cnt_q    <= '0;
      inflight_q    <= '0;
    end else if (flush_i) begin
      data_wr_ptr_q <= '0;
      data_rd_ptr_q <= '0;
      data_cnt_q    <= '0;
      inflight_q    <= '0;
    end else begin
      if (operand_valid_i) begin
        data_wr_ptr_q <= (data_wr_ptr_q == DataPtrW'(DataDepth - 1)) ? '0 :
                         data_wr_ptr_q + 1'b1;
      end
      if (data_pop) begin
        data_rd_ptr_q <= (data_rd_ptr_q == DataPtrW'(DataDepth - 1)) ? '0 :
                         data_rd_ptr_q + 1'b1;
      end
      case ({operand_valid_i, data_pop})
        2'b10:   data_cnt_q <= data_cnt_q + 1'b1;
        2'b01:   data_cnt_q <= data_cnt_q - 1'b1;
        default: data_cnt_q <= data_cnt_q;
      endcase
      // An arriving element turns one in-flight read into a stored one
      case ({operand_issued_i, operand_valid_i})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  ////////////////////////////////////////
  // Command side
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cmd_wr_ptr_q <= '0;
      cmd_rd_ptr_q <= '0;
      cmd_cnt_q    <= '0;
      elem_cnt_q   <= '0;
      cmd_pop_q    <= 1'b0;
    end else if (flush_i) begin
      cmd_wr_ptr_q <= '0;
      cmd_rd_ptr_q <= '0;
      cmd_cnt_q    <= '0;
      elem_cnt_q   <= '0;
      cmd_pop_q    <= 1'b0;
    end else begin
      cmd_pop_q <= cmd_done;
      if (cmd_valid_i) begin
        cmd_wr_ptr_q <= (cmd_wr_ptr_q == CmdPtrW'(CmdDepth - 1)) ? '0 :
                        cmd_wr_ptr_q + 1'b1;
      end
      if (cmd_done) begin
        cmd_rd_ptr_q <= (cmd_rd_ptr_q == CmdPtrW'(CmdDepth - 1)) ? '0 :
                        cmd_rd_ptr_q + 1'b1;
      end
      case ({cmd_valid_i, cmd_done})
        2'b10:   cmd_cnt_q <= cmd_cnt_q + 1'b1;
        2'b01:   cmd_cnt_q <= cmd_cnt_q - 1'b1;
        default: cmd_cnt_q <= cmd_cnt_q;
      endcase
      if (data_pop) begin
        elem_cnt_q <= last_elem ? '0 : elem_cnt_q + 1'b1;
      end
    end
  end

  // Requester must respect the space and credit it is shown
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_valid_i |-> !cmd_full)
    else $error("Command pushed into a full command buffer");

  assert property (@(posedge clk_i) disable iff (!arst_n_i || flush_i)
    operand_valid_i |-> (inflight_q != '0))
    else $error("Operand arrived without an in-flight read");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    operand_issued_i |-> operand_queue_ready_o)
    else $error("Read issued while the queue had no credit");

endmodule

/* perm_operand_path.sv */
`timescale 1ns/1ps
////////////////////////////////////////
// Index and value permutation queues on one shared wide bus
////////////////////////////////////////

`include "oq_macros.svh"

module perm_operand_path (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Shared input bus from the register file
  input  oq_pkg::perm_word_t    perm_operand_i,
  input  logic                  perm_operand_valid_i,
  input  oq_pkg::opqueue_e      perm_opqueue_i,
  // Requester side with [0] for index and [1] for value
  input  oq_pkg::oq_cmd_t [1:0] cmd_i,
  input  logic            [1:0] cmd_valid_i,
  input  logic            [1:0] operand_issued_i,
  output logic            [1:0] operand_queue_ready_o,
  // Shared output bus
  output oq_pkg::perm_word_t    perm_operand_o,
  output logic                  perm_operand_valid_o,
  output logic                  perm_sel_idx_val_o,
  input  logic                  perm_operand_ready_i,
  output logic                  perm_cmd_pop_o
);

  import oq_pkg::*;

  perm_word_t [1:0] q_operand;
  logic       [1:0] q_in_valid;
  logic       [1:0] q_valid;
  logic       [1:0] q_ready;
  logic       [1:0] gnt;

  // Input demux by target queue
  assign q_in_valid[0] = perm_operand_valid_i && (perm_opqueue_i == perm_idx);
  assign q_in_valid[1] = perm_operand_valid_i && (perm_opqueue_i == perm_val);

  operand_queue #(
    .payload_t(perm_word_t),
    .DataDepth(`OQ_PERM_DEPTH),
    .CmdDepth (`OQ_CMD_DEPTH)
  ) u_perm_idx_queue (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .flush_i              (1'b0),
    .cmd_i                (cmd_i[0]),
    .cmd_valid_i          (cmd_valid_i[0]),
    .cmd_pop_o            (),
    .operand_i            (perm_operand_i),
    .operand_valid_i      (q_in_valid[0]),
    .operand_issued_i     (operand_issued_i[0]),
    .operand_queue_ready_o(operand_queue_ready_o[0]),
    .operand_o            (q_operand[0]),
    .valid_o              (q_valid[0]),
    .ready_i              (q_ready[0])
  );

  operand_queue #(
    .payload_t(perm_word_t),
    .DataDepth(`OQ_PERM_DEPTH),
    .CmdDepth (`OQ_CMD_DEPTH)
  ) u_perm_val_queue (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .flush_i              (1'b0),
    .cmd_i                (cmd_i[1]),
    .cmd_valid_i          (cmd_valid_i[1]),
    .cmd_pop_o            (perm_cmd_pop_o),
    .operand_i            (perm_operand_i),
    .operand_valid_i      (q_in_valid[1]),
    .operand_issued_i     (operand_issued_i[1]),
    .operand_queue_ready_o(operand_queue_ready_o[1]),
    .operand_o            (q_operand[1]),
    .valid_o              (q_valid[1]),
    .ready_i              (q_ready[1])
  );

  ////////////////////////////////////////
  // Fixed priority with index first
  ////////////////////////////////////////

  assign gnt[0] = q_valid[0];
  assign gnt[1] = q_valid[1] && !q_valid[0];
  assign q_ready = gnt & {2{perm_operand_ready_i}};

  assign perm_operand_valid_o = |q_valid;
  assign perm_sel_idx_val_o   = !gnt[0];
  assign perm_operand_o       = gnt[0] ? q_operand[0] : q_operand[1];

  // Shared bus words only target the two permutation queues
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    perm_operand_valid_i |-> (perm_opqueue_i inside {perm_idx, perm_val}))
    else $error("Permutation word sent to a non-permutation queue");

endmodule

/* operand_queues_stage.sv */
`timescale 1ns/1ps
////////////////////////////////////////
// Operand queue stage of one lane, top level
// Holds ALU, store and permutation queues plus the store flush register
////////////////////////////////////////

`include "oq_macros.svh"

module operand_queues_stage (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  // Register file and operand requester
  input  oq_pkg::elen_t   [`OQ_NR_ELEN_QUEUES-1:0] operand_i,
  input  logic            [`OQ_NR_QUEUES-1:0]      operand_valid_i,
  input  logic            [`OQ_NR_QUEUES-1:0]      operand_issued_i,
  output logic            [`OQ_NR_QUEUES-1:0]      operand_queue_ready_o,
  input  oq_pkg::oq_cmd_t [`OQ_NR_QUEUES-1:0]      cmd_i,
  input  logic            [`OQ_NR_QUEUES-1:0]      cmd_valid_i,
  // Store exception flush
  input  logic                                     lsu_ex_flush_i,
  output logic                                     lsu_ex_flush_o,
  // ALU
  output oq_pkg::elen_t   [1:0]                    alu_operand_o,
  output logic            [1:0]                    alu_operand_valid_o,
  input  logic            [1:0]                    alu_operand_ready_i,
  // Store unit
  output oq_pkg::elen_t                            stu_operand_o,
  output logic                                     stu_operand_valid_o,
  input  logic                                     stu_operand_ready_i,
  // Permutation bus
  input  oq_pkg::perm_word_t                       perm_operand_i,
  input  logic                                     perm_operand_valid_i,
  input  oq_pkg::opqueue_e                         perm_opqueue_i,
  output oq_pkg::perm_word_t                       perm_operand_o,
  output logic                                     perm_operand_valid_o,
  output logic                                     perm_sel_idx_val_o,
  input  logic                                     perm_operand_ready_i,
  output logic                                     perm_cmd_pop_o
);

  import oq_pkg::*;

  logic [1:0] perm_queue_ready;

  // Flush reaches the store queue one cycle late
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lsu_ex_flush_o <= 1'b0;
    end else begin
      lsu_ex_flush_o <= lsu_ex_flush_i;
    end
  end

  ////////////////////////////////////////
  // ALU and store queues
  ////////////////////////////////////////

  for (genvar i = 0; i < 2; i++) begin : g_alu
    operand_queue #(
      .payload_t(elen_t),
      .DataDepth(`OQ_ALU_DEPTH),
      .CmdDepth (`OQ_CMD_DEPTH)
    ) u_alu_queue (
      .clk_i                (clk_i),
      .arst_n_i             (arst_n_i),
      .flush_i              (1'b0),
      .cmd_i                (cmd_i[i]),
      .cmd_valid_i          (cmd_valid_i[i]),
      .cmd_pop_o            (),
      .operand_i            (operand_i[i]),
      .operand_valid_i      (operand_valid_i[i]),
      .operand_issued_i     (operand_issued_i[i]),
      .operand_queue_ready_o(operand_queue_ready_o[i]),
      .operand_o            (alu_operand_o[i]),
      .valid_o              (alu_operand_valid_o[i]),
      .ready_i              (alu_operand_ready_i[i])
    );
  end

  operand_queue #(
    .payload_t(elen_t),
    .DataDepth(`OQ_ST_DEPTH),
    .CmdDepth (`OQ_CMD_DEPTH)
  ) u_st_queue (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .flush_i              (lsu_ex_flush_o),
    .cmd_i                (cmd_i[st_a]),
    .cmd_valid_i          (cmd_valid_i[st_a]),
    .cmd_pop_o            (),
    .operand_i            (operand_i[st_a]),
    .operand_valid_i      (operand_valid_i[st_a]),
    .operand_issued_i     (operand_issued_i[st_a]),
    .operand_queue_ready_o(operand_queue_ready_o[st_a]),
    .operand_o            (stu_operand_o),
    .valid_o              (stu_operand_valid_o),
    .ready_i              (stu_operand_ready_i)
  );

  ////////////////////////////////////////
  // Permutation pair
  ////////////////////////////////////////

  perm_operand_path u_perm_path (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .perm_operand_i       (perm_operand_i),
    .perm_operand_valid_i (perm_operand_valid_i),
    .perm_opqueue_i       (perm_opqueue_i),
    .cmd_i                ({cmd_i[perm_val], cmd_i[perm_idx]}),
    .cmd_valid_i          ({cmd_valid_i[perm_val], cmd_valid_i[perm_idx]}),
    .operand_issued_i     ({operand_issued_i[perm_val], operand_issued_i[perm_idx]}),
    .operand_queue_ready_o(perm_queue_ready),
    .perm_operand_o       (perm_operand_o),
    .perm_operand_valid_o (perm_operand_valid_o),
    .perm_sel_idx_val_o   (perm_sel_idx_val_o),
    .perm_operand_ready_i (perm_operand_ready_i),
    .perm_cmd_pop_o       (perm_cmd_pop_o)
  );

  assign operand_queue_ready_o[perm_idx] = perm_queue_ready[0];
  assign operand_queue_ready_o[perm_val] = perm_queue_ready[1];

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps
////////////////////////////////////////
// Testbench clock and active-low reset
////////////////////////////////////////

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 100,
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Held over a few rising edges, released on a falling one
  initial begin
    arst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

/* tb_operand_queues_stage.sv */
`timescale 1ns/1ps
////////////////////////////////////////
// Testbench for the operand queue stage
// Random requester traffic checked against a queue model every cycle
////////////////////////////////////////

`include "oq_macros.svh"

module tb_operand_queues_stage;

  import oq_pkg::*;

  localparam int NQ = `OQ_NR_QUEUES;
  localparam int WW = `OQ_ELEN * `OQ_NR_BANKS;
  // Five phases of up to about 400 cycles plus half again as margin
  localparam int TimeoutCycles = 5 * 400 * 3 / 2;

  logic clk;
  logic arst_n;

  elen_t      [`OQ_NR_ELEN_QUEUES-1:0] operand;
  logic       [NQ-1:0] operand_valid;
  logic       [NQ-1:0] operand_issued;
  logic       [NQ-1:0] queue_ready;
  oq_cmd_t    [NQ-1:0] cmd;
  logic       [NQ-1:0] cmd_valid;
  logic                flush_in;
  logic                flush_out;
  elen_t      [1:0]    alu_operand;
  logic       [1:0]    alu_valid;
  logic       [1:0]    alu_ready;
  elen_t               stu_operand;
  logic                stu_valid;
  logic                stu_ready;
  perm_word_t          perm_in;
  logic                perm_in_valid;
  opqueue_e            perm_queue_sel;
  perm_word_t          perm_out;
  logic                perm_valid;
  logic                perm_sel;
  logic                perm_ready;
  logic                perm_cmd_pop;

  // Queue model with one entry per queue
  logic [WW-1:0] mdata     [NQ][$];
  int            mcmd      [NQ][$];
  int            melem     [NQ];
  int            minflight [NQ];
  logic          flush_q;
  logic          pop_exp;
  int            pop_seen;

  // Requester state
  int            to_issue [NQ];
  int            due      [NQ][$];
  int            cmd_req  [NQ][$];
  // FU ready bits for alu a, alu b, store and perm
  logic [3:0]    fu_rand;
  logic [3:0]    fu_level;
  int            cycle = 0;
  int            error_cnt;
  integer        seed;

  tb_clock_gen #(.PeriodNs(100), .ResetCycles(4)) u_clock_gen (
    .clk_o   (clk),
    .arst_n_o(arst_n)
  );

  operand_queues_stage dut (
    .clk_i                (clk),
    .arst_n_i             (arst_n),
    .operand_i            (operand),
    .operand_valid_i      (operand_valid),
    .operand_issued_i     (operand_issued),
    .operand_queue_ready_o(queue_ready),
    .cmd_i                (cmd),
    .cmd_valid_i          (cmd_valid),
    .lsu_ex_flush_i       (flush_in),
    .lsu_ex_flush_o       (flush_out),
    .alu_operand_o        (alu_operand),
    .alu_operand_valid_o  (alu_valid),
    .alu_operand_ready_i  (alu_ready),
    .stu_operand_o        (stu_operand),
    .stu_operand_valid_o  (stu_valid),
    .stu_operand_ready_i  (stu_ready),
    .perm_operand_i       (perm_in),
    .perm_operand_valid_i (perm_in_valid),
    .perm_opqueue_i       (perm_queue_sel),
    .perm_operand_o       (perm_out),
    .perm_operand_valid_o (perm_valid),
    .perm_sel_idx_val_o   (perm_sel),
    .perm_operand_ready_i (perm_ready),
    .perm_cmd_pop_o       (perm_cmd_pop)
  );

  ////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////

  function automatic elen_t rand_elem();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  function automatic int depth_of(input int q);
    if (q < 2) return `OQ_ALU_DEPTH;
    if (q == 2) return `OQ_ST_DEPTH;
    return `OQ_PERM_DEPTH;
  endfunction

  function automatic logic [WW-1:0] head_of(input int q);
    return (mdata[q].size() > 0) ? mdata[q][0] : '0;
  endfunction

  // In-flight plus stored must stay below the depth
  function automatic logic ready_expected(input int q);
    return (minflight[q] + mdata[q].size()) < depth_of(q);
  endfunction

  // Index queue wins the bus and the result packs {valid, sel, word}
  function automatic logic [WW+1:0] expected_perm(input logic idx_valid,
      input logic val_valid, input logic [WW-1:0] idx_head, input logic [WW-1:0] val_head);
    if (idx_valid) return {1'b1, 1'b0, idx_head};
    if (val_valid) return {1'b1, 1'b1, val_head};
    return {1'b0, 1'b1, {WW{1'b0}}};
  endfunction

  function automatic logic all_idle();
    for (int q = 0; q < NQ; q++) begin
      if (to_issue[q] != 0 || due[q].size() != 0 || cmd_req[q].size() != 0 ||
          mdata[q].size() != 0 || mcmd[q].size() != 0 || minflight[q] != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic check(input string name, input logic [WW-1:0] expected,
      input logic [WW-1:0] actual);
    if (actual !== expected) begin
      error_cnt++;
      $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////
  // Requester and FU stimulus
  ////////////////////////////////////////

  always @(negedge clk) begin : drive
    logic [31:0] r;
    cmd_valid      = '0;
    operand_issued = '0;
    operand_valid  = '0;
    perm_in_valid  = 1'b0;
    if (arst_n) begin
      for (int q = 0; q < NQ; q++) begin
        if (cmd_req[q].size() > 0 && mcmd[q].size() < `OQ_CMD_DEPTH) begin
          cmd[q].vl    = vl_t'(cmd_req[q].pop_front());
          cmd_valid[q] = 1'b1;
        end
        if (to_issue[q] > 0 && queue_ready[q] && rand_below(4) != 0) begin
          operand_issued[q] = 1'b1;
          to_issue[q]--;
          // Data comes back one to three cycles later
          due[q].push_back(cycle + 1 + rand_below(3));
        end
      end
      for (int q = 0; q < `OQ_NR_ELEN_QUEUES; q++) begin
        if (due[q].size() > 0 && due[q][0] <= cycle) begin
          void'(due[q].pop_front());
          operand[q]       = rand_elem();
          operand_valid[q] = 1'b1;
        end
      end
      // One permutation word per cycle on the shared bus
      for (int q = int'(perm_idx); q <= int'(perm_val); q++) begin
        if (!perm_in_valid && due[q].size() > 0 && due[q][0] <= cycle) begin
          void'(due[q].pop_front());
          perm_in        = {rand_elem(), rand_elem(), rand_elem(), rand_elem()};
          perm_in_valid  = 1'b1;
          perm_queue_sel = opqueue_e'(q);
        end
      end
      r = $random(seed);
      alu_ready[0] = fu_rand[0] ? r[0] : fu_level[0];
      alu_ready[1] = fu_rand[1] ? r[1] : fu_level[1];
      stu_ready    = fu_rand[2] ? r[2] : fu_level[2];
      perm_ready   = fu_rand[3] ? r[3] : fu_level[3];
    end
  end

  ////////////////////////////////////////
  // Compare against the model
  ////////////////////////////////////////

  always @(posedge clk) begin : compare
    logic [NQ-1:0] exp_valid;
    logic [NQ-1:0] xfer;
    logic [WW+1:0] exp_perm;
    logic          arrived;
    logic [WW-1:0] arrived_data;
    logic          pop_next;
    if (arst_n) begin
      for (int q = 0; q < NQ; q++) begin
        exp_valid[q] = mdata[q].size() > 0 && mcmd[q].size() > 0;
      end
      exp_perm = expected_perm(exp_valid[perm_idx], exp_valid[perm_val],
                               head_of(perm_idx), head_of(perm_val));
      for (int i = 0; i < 2; i++) begin
        check($sformatf("alu_operand_valid_o[%0d]", i), WW'(exp_valid[i]), WW'(alu_valid[i]));
        if (exp_valid[i]) begin
          check($sformatf("alu_operand_o[%0d]", i), head_of(i), WW'(alu_operand[i]));
        end
      end
      check("stu_operand_valid_o", WW'(exp_valid[st_a]), WW'(stu_valid));
      if (exp_valid[st_a]) begin
        check("stu_operand_o", head_of(st_a), WW'(stu_operand));
      end
      check("perm_operand_valid_o", WW'(exp_perm[WW+1]), WW'(perm_valid));
      if (exp_perm[WW+1]) begin
        check("perm_sel_idx_val_o", WW'(exp_perm[WW]), WW'(perm_sel));
        check("perm_operand_o", exp_perm[WW-1:0], perm_out);
      end
      for (int q = 0; q < NQ; q++) begin
        check($sformatf("operand_queue_ready_o[%0d]", q), WW'(ready_expected(q)),
              WW'(queue_ready[q]));
      end
      check("lsu_ex_flush_o", WW'(flush_q), WW'(flush_out));
      check("perm_cmd_pop_o", WW'(pop_exp), WW'(perm_cmd_pop));
      if (perm_cmd_pop) pop_seen++;

      xfer[alu_a]    = exp_valid[alu_a] && alu_ready[0];
      xfer[alu_b]    = exp_valid[alu_b] && alu_ready[1];
      xfer[st_a]     = exp_valid[st_a] && stu_ready;
      xfer[perm_idx] = exp_valid[perm_idx] && perm_ready;
      xfer[perm_val] = exp_valid[perm_val] && !exp_valid[perm_idx] && perm_ready;
      pop_next = 1'b0;
      for (int q = 0; q < NQ; q++) begin
        if (q == int'(st_a) && flush_q) begin
          mdata[q].delete();
          mcmd[q].delete();
          melem[q]     = 0;
          minflight[q] = 0;
        end else begin
          if (xfer[q]) begin
            void'(mdata[q].pop_front());
            melem[q]++;
            if (melem[q] == mcmd[q][0]) begin
              void'(mcmd[q].pop_front());
              melem[q] = 0;
              pop_next |= (q == int'(perm_val));
            end
          end
          if (q < `OQ_NR_ELEN_QUEUES) begin
            arrived      = operand_valid[q];
            arrived_data = WW'(operand[q]);
          end else begin
            arrived      = perm_in_valid && int'(perm_queue_sel) == q;
            arrived_data = perm_in;
          end
          if (arrived) begin
            mdata[q].push_back(arrived_data);
            minflight[q]--;
          end
          if (operand_issued[q]) minflight[q]++;
          if (cmd_valid[q]) mcmd[q].push_back(int'(cmd[q].vl));
        end
      end
      pop_exp = pop_next;
      flush_q = flush_in;
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TimeoutCycles) begin
      $display("Timeout: the test did not complete within %0d cycles", TimeoutCycles);
      $display("Errors found");
      $fatal(1);
    end
  end

  ////////////////////////////////////////
  // Test phases
  ////////////////////////////////////////

  task automatic push_cmd(input int q, input int n);
    cmd_req[q].push_back(n);
    to_issue[q] += n;
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (!all_idle()) @(negedge clk);
  endtask

  task automatic alu_phase();
    fu_rand[1:0] = 2'b11;
    for (int k = 0; k < 6; k++) begin
      push_cmd(alu_a, 1 + rand_below(8));
      push_cmd(alu_b, 1 + rand_below(8));
    end
    wait_idle();
  endtask

  // Stalled FU fills the buffer and drops the credit
  task automatic credit_phase();
    fu_rand[0]  = 1'b0;
    fu_level[0] = 1'b0;
    push_cmd(alu_a, 8);
    repeat (30) @(negedge clk);
    check("operand_queue_ready_o[alu_a]", '0, WW'(queue_ready[alu_a]));
    fu_rand[0] = 1'b1;
    wait_idle();
  endtask

  task automatic no_cmd_phase();
    int pops;
    fu_rand[3] = 1'b1;
    to_issue[perm_val] += 3;
    while (mdata[perm_val].size() < 3) @(negedge clk);
    repeat (10) @(negedge clk);
    pops = pop_seen;
    cmd_req[perm_val].push_back(3);
    wait_idle();
    repeat (2) @(negedge clk);
    check("perm_cmd_pop_o pulse count", WW'(1), WW'(pop_seen - pops));
  endtask

  task automatic flush_phase();
    fu_rand[2]  = 1'b0;
    fu_level[2] = 1'b0;
    push_cmd(st_a, 2);
    while (mdata[st_a].size() < 2) @(negedge clk);
    flush_in = 1'b1;
    @(negedge clk);
    flush_in = 1'b0;
    repeat (3) @(negedge clk);
    check("stu_operand_valid_o", '0, WW'(stu_valid));
    // Fresh elements only from here on
    fu_rand[2] = 1'b1;
    push_cmd(st_a, 3);
    wait_idle();
  endtask

  task automatic perm_phase();
    int n_idx;
    int n_val;
    for (int k = 0; k < 3; k++) begin
      fu_rand[3]  = 1'b0;
      fu_level[3] = 1'b0;
      n_idx = 1 + rand_below(4);
      n_val = 1 + rand_below(4);
      push_cmd(perm_idx, n_idx);
      push_cmd(perm_val, n_val);
      while (mdata[perm_idx].size() < n_idx || mdata[perm_val].size() < n_val) begin
        @(negedge clk);
      end
      fu_rand[3] = 1'b1;
      wait_idle();
    end
  endtask

  initial begin
    seed           = 32'hec75;
    operand        = '0;
    operand_valid  = '0;
    operand_issued = '0;
    cmd            = '0;
    cmd_valid      = '0;
    flush_in       = 1'b0;
    alu_ready      = '0;
    stu_ready      = 1'b0;
    perm_in        = '0;
    perm_in_valid  = 1'b0;
    perm_queue_sel = perm_idx;
    perm_ready     = 1'b0;
    fu_rand        = '0;
    fu_level       = '0;
    flush_q        = 1'b0;
    pop_exp        = 1'b0;
    pop_seen       = 0;
    error_cnt      = 0;
    for (int q = 0; q < NQ; q++) begin
      melem[q]     = 0;
      minflight[q] = 0;
      to_issue[q]  = 0;
    end
    @(posedge arst_n);
    @(negedge clk);
    alu_phase();
    credit_phase();
    no_cmd_phase();
    flush_phase();
    perm_phase();
    repeat (4) @(negedge clk);
    if (error_cnt == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1);
    end
  end

endmodule

/* flist.f */
+incdir+.
oq_pkg.sv
operand_queue.sv
perm_operand_path.sv
operand_queues_stage.sv
tb_clock_gen.sv
tb_operand_queues_stage.sv

/* Makefile */
TOP := tb_operand_queues_stage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim

# The log decides pass or fail
run: build
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	grep -q "No errors" sim.log

lint:
	verilator --lint-only --timing -f flist.f --top-module operand_queues_stage

clean:
	rm -rf obj_dir sim.log
